// File: hw/riscv_pkg.sv
package riscv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B // result is operand b unchanged, used by LUI
	} alu_op_e;

	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t inst;
	} if_id_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		alu_op_e  alu_op;
		logic     use_imm;
		logic     load;
		logic     store;
		logic     wr_en;
		word_t    op_a;
		word_t    op_b; // rs2 value, also the store data
		word_t    imm;
	} id_ex_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		logic     load;
		logic     store;
		logic     wr_en;
		word_t    alu_result;
		word_t    store_data;
	} ex_mem_t;

	typedef struct packed {
		logic     valid;
		logic     wr_en;
		reg_idx_t rd;
		word_t    result;
	} mem_wb_t;

endpackage

// File: hw/pipe_reg.sv
module pipe_reg #(
	parameter type T = logic
) (
	input  logic i_clk,
	input  logic i_arst_n,
	input  T     i_d,
	output T     o_q
);

	// an all-zero payload has its valid flag low
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_q <= '0;
		end else begin
			o_q <= i_d;
		end
	end

endmodule

// File: hw/fetch_stage.sv
module fetch_stage import riscv_pkg::*; (
	input  logic   i_clk,
	input  logic   i_arst_n,
	input  logic   i_run,
	input  logic   i_branch_taken,
	input  word_t  i_branch_target,
	input  word_t  i_inst,
	output word_t  o_pc,
	output if_id_t o_if_id
);

	word_t pc_q;
	word_t pc_next;

	always_comb begin
		if (!i_run) begin
			pc_next = '0; // parked at the reset vector while loading
		end else if (i_branch_taken) begin
			pc_next = i_branch_target;
		end else begin
			pc_next = pc_q + 32'd4;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pc_q <= '0;
		end else begin
			pc_q <= pc_next;
		end
	end

	assign o_pc = pc_q;

	always_comb begin
		o_if_id.valid = i_run;
		o_if_id.pc    = pc_q;
		o_if_id.inst  = i_inst;
	end

endmodule

// File: hw/decode_stage.sv
module decode_stage import riscv_pkg::*; (
	input  logic    i_clk,
	input  logic    i_arst_n,
	input  if_id_t  i_if_id,
	input  mem_wb_t i_mem_wb,
	output logic    o_branch_taken,
	output word_t   o_branch_target,
	output id_ex_t  o_id_ex
);

	word_t      regs [32];
	reg_idx_t   rs1;
	reg_idx_t   rs2;
	word_t      rs1_val;
	word_t      rs2_val;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_u;
	word_t      imm_b;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       wb_we;
	logic       known;
	logic       taken;

	assign rs1    = i_if_id.inst[19:15];
	assign rs2    = i_if_id.inst[24:20];
	assign funct3 = i_if_id.inst[14:12];
	assign funct7 = i_if_id.inst[31:25];

	assign imm_i = {{20{i_if_id.inst[31]}}, i_if_id.inst[31:20]};
	assign imm_s = {{20{i_if_id.inst[31]}}, i_if_id.inst[31:25], i_if_id.inst[11:7]};
	assign imm_u = {i_if_id.inst[31:12], 12'b0};
	assign imm_b = {{19{i_if_id.inst[31]}}, i_if_id.inst[31], i_if_id.inst[7],
		i_if_id.inst[30:25], i_if_id.inst[11:8], 1'b0};

	assign wb_we = i_mem_wb.valid && i_mem_wb.wr_en && (i_mem_wb.rd != '0);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			regs <= '{default: '0};
		end else if (wb_we) begin
			regs[i_mem_wb.rd] <= i_mem_wb.result;
		end
	end

	// x0 is never written, so it keeps reading zero
	assign rs1_val = (wb_we && i_mem_wb.rd == rs1) ? i_mem_wb.result : regs[rs1];
	assign rs2_val = (wb_we && i_mem_wb.rd == rs2) ? i_mem_wb.result : regs[rs2];

	always_comb begin
		o_id_ex      = '0;
		o_id_ex.rd   = i_if_id.inst[11:7];
		o_id_ex.op_a = rs1_val;
		o_id_ex.op_b = rs2_val;
		known        = 1'b0;
		taken        = 1'b0;
		case (opcode_e'(i_if_id.inst[6:0]))
			OPC_OP: begin
				o_id_ex.wr_en = 1'b1;
				if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					o_id_ex.alu_op = ALU_SUB;
					known          = 1'b1;
				end else if (funct7 == 7'b0000000) begin
					known = 1'b1;
					case (funct3)
						3'b000:  o_id_ex.alu_op = ALU_ADD;
						3'b100:  o_id_ex.alu_op = ALU_XOR;
						3'b110:  o_id_ex.alu_op = ALU_OR;
						3'b111:  o_id_ex.alu_op = ALU_AND;
						default: known = 1'b0;
					endcase
				end
			end
			OPC_OP_IMM: begin
				known           = (funct3 == 3'b000); // only ADDI
				o_id_ex.wr_en   = 1'b1;
				o_id_ex.use_imm = 1'b1;
				o_id_ex.imm     = imm_i;
			end
			OPC_LUI: begin
				known           = 1'b1;
				o_id_ex.wr_en   = 1'b1;
				o_id_ex.use_imm = 1'b1;
				o_id_ex.alu_op  = ALU_PASS_B;
				o_id_ex.imm     = imm_u;
			end
			OPC_LOAD: begin
				known           = (funct3 == 3'b010);
				o_id_ex.wr_en   = 1'b1;
				o_id_ex.load    = 1'b1;
				o_id_ex.use_imm = 1'b1;
				o_id_ex.imm     = imm_i;
			end
			OPC_STORE: begin
				known           = (funct3 == 3'b010);
				o_id_ex.store   = 1'b1;
				o_id_ex.use_imm = 1'b1;
				o_id_ex.imm     = imm_s;
			end
			OPC_BRANCH: begin
				// a branch travels on as a valid payload that writes nothing
				known = (funct3 == 3'b000) || (funct3 == 3'b001);
				taken = (funct3[0]) ? (rs1_val != rs2_val) : (rs1_val == rs2_val);
			end
			default: known = 1'b0;
		endcase
		o_id_ex.valid  = known && i_if_id.valid;
		o_branch_taken = known && taken && i_if_id.valid;
	end

	assign o_branch_target = i_if_id.pc + imm_b;

endmodule

// File: hw/execute_stage.sv
module execute_stage import riscv_pkg::*; (
	input  id_ex_t  i_id_ex,
	output ex_mem_t o_ex_mem
);

	word_t operand_a;
	word_t operand_b;
	word_t alu_out;

	assign operand_a = i_id_ex.op_a;
	assign operand_b = i_id_ex.use_imm ? i_id_ex.imm : i_id_ex.op_b;

	always_comb begin
		case (i_id_ex.alu_op)
			ALU_ADD: begin
				alu_out = operand_a + operand_b; // wraps at 32 bits
			end
			ALU_SUB: begin
				alu_out = operand_a - operand_b;
			end
			ALU_AND: begin
				alu_out = operand_a & operand_b;
			end
			ALU_OR: begin
				alu_out = operand_a | operand_b;
			end
			ALU_XOR: begin
				alu_out = operand_a ^ operand_b;
			end
			ALU_PASS_B: begin
				alu_out = operand_b;
			end
			default: begin
				alu_out = '0;
			end
		endcase
	end

	always_comb begin
		o_ex_mem.valid      = i_id_ex.valid;
		o_ex_mem.rd         = i_id_ex.rd;
		o_ex_mem.load       = i_id_ex.load;
		o_ex_mem.store      = i_id_ex.store;
		o_ex_mem.wr_en      = i_id_ex.wr_en;
		o_ex_mem.alu_result = alu_out; // doubles as the load/store address
		o_ex_mem.store_data = i_id_ex.op_b;
	end

endmodule

// File: hw/memory_controller.sv
module memory_controller import riscv_pkg::*; #(
	parameter int IMEM_DEPTH = 64,
	parameter int DMEM_DEPTH = 64
) (
	input  logic                          i_clk,
	input  logic                          i_arst_n,
	input  logic                          i_load_en,
	input  logic [$clog2(IMEM_DEPTH)-1:0] i_load_addr,
	input  word_t                         i_load_data,
	input  word_t                         i_pc,
	input  ex_mem_t                       i_ex_mem,
	output word_t                         o_inst,
	output mem_wb_t                       o_mem_wb,
	output logic [3:0]                    o_leds
);

	localparam int IMEM_AW = $clog2(IMEM_DEPTH);
	localparam int DMEM_AW = $clog2(DMEM_DEPTH);

	word_t              imem [IMEM_DEPTH];
	word_t              dmem [DMEM_DEPTH];
	logic [IMEM_AW-1:0] pc_idx;
	logic [DMEM_AW-1:0] data_idx;
	logic               do_store;
	logic [3:0]         leds_q;

	// word addresses drop the byte offset and wrap at the RAM depth
	assign pc_idx   = i_pc[IMEM_AW+1:2];
	assign data_idx = i_ex_mem.alu_result[DMEM_AW+1:2];
	assign do_store = i_ex_mem.valid && i_ex_mem.store;

	always_ff @(posedge i_clk) begin
		if (i_load_en) begin
			imem[i_load_addr] <= i_load_data;
		end
	end

	assign o_inst = imem[pc_idx];

	always_ff @(posedge i_clk) begin
		if (do_store) begin
			dmem[data_idx] <= i_ex_mem.store_data;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			leds_q <= '0;
		end else if (do_store && data_idx == '0) begin
			leds_q <= i_ex_mem.store_data[3:0]; // word 0 is mapped onto the LEDs
		end
	end

	assign o_leds = leds_q;

	always_comb begin
		o_mem_wb.valid  = i_ex_mem.valid;
		o_mem_wb.wr_en  = i_ex_mem.wr_en;
		o_mem_wb.rd     = i_ex_mem.rd;
		o_mem_wb.result = i_ex_mem.load ? dmem[data_idx] : i_ex_mem.alu_result;
	end

endmodule

// File: hw/riscv_core.sv
module riscv_core import riscv_pkg::*; #(
	parameter int IMEM_DEPTH = 64,
	parameter int DMEM_DEPTH = 64
) (
	input  logic                          i_clk,
	input  logic                          i_arst_n,
	input  logic                          i_run,
	input  logic                          i_load_en,
	input  logic [$clog2(IMEM_DEPTH)-1:0] i_load_addr,
	input  word_t                         i_load_data,
	output logic                          o_wb_en,
	output reg_idx_t                      o_wb_rd,
	output word_t                         o_wb_data,
	output logic [3:0]                    o_leds
);

	word_t   pc;
	word_t   inst;
	logic    branch_taken;
	word_t   branch_target;
	if_id_t  if_id_d;
	if_id_t  if_id_q;
	id_ex_t  id_ex_d;
	id_ex_t  id_ex_q;
	ex_mem_t ex_mem_d;
	ex_mem_t ex_mem_q;
	mem_wb_t mem_wb_d;
	mem_wb_t mem_wb_q;

	fetch_stage u_fetch (
		.i_clk           (i_clk),
		.i_arst_n        (i_arst_n),
		.i_run           (i_run),
		.i_branch_taken  (branch_taken),
		.i_branch_target (branch_target),
		.i_inst          (inst),
		.o_pc            (pc),
		.o_if_id         (if_id_d)
	);

	pipe_reg #(.T(if_id_t)) u_if_id (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_d      (if_id_d),
		.o_q      (if_id_q)
	);

	decode_stage u_decode (
		.i_clk           (i_clk),
		.i_arst_n        (i_arst_n),
		.i_if_id         (if_id_q),
		.i_mem_wb        (mem_wb_q),
		.o_branch_taken  (branch_taken),
		.o_branch_target (branch_target),
		.o_id_ex         (id_ex_d)
	);

	pipe_reg #(.T(id_ex_t)) u_id_ex (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_d      (id_ex_d),
		.o_q      (id_ex_q)
	);

	execute_stage u_execute (
		.i_id_ex  (id_ex_q),
		.o_ex_mem (ex_mem_d)
	);

	pipe_reg #(.T(ex_mem_t)) u_ex_mem (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_d      (ex_mem_d),
		.o_q      (ex_mem_q)
	);

	memory_controller #(
		.IMEM_DEPTH (IMEM_DEPTH),
		.DMEM_DEPTH (DMEM_DEPTH)
	) u_mem (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_load_en   (i_load_en),
		.i_load_addr (i_load_addr),
		.i_load_data (i_load_data),
		.i_pc        (pc),
		.i_ex_mem    (ex_mem_q),
		.o_inst      (inst),
		.o_mem_wb    (mem_wb_d),
		.o_leds      (o_leds)
	);

	pipe_reg #(.T(mem_wb_t)) u_mem_wb (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_d      (mem_wb_d),
		.o_q      (mem_wb_q)
	);

	// the same payload feeds the register file write in decode
	assign o_wb_en   = mem_wb_q.valid && mem_wb_q.wr_en && (mem_wb_q.rd != '0);
	assign o_wb_rd   = mem_wb_q.rd;
	assign o_wb_data = mem_wb_q.result;

endmodule

// File: tests/riscv_core_tb.sv
module riscv_core_tb import riscv_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int    IMEM_DEPTH     = 64;
	localparam int    ADDR_W         = $clog2(IMEM_DEPTH);
	localparam int    TIMEOUT_CYCLES = 200;
	localparam int    DRAIN_CYCLES   = 6;
	localparam int    QUIET_CYCLES   = 8;
	localparam word_t NOP_INST       = 32'h0000_0013; // addi x0, x0, 0

	logic              clk = 1'b0;
	logic              arst_n;
	logic              run;
	logic              load_en;
	logic [ADDR_W-1:0] load_addr;
	word_t             load_data;
	logic              wb_en;
	reg_idx_t          wb_rd;
	word_t             wb_data;
	logic [3:0]        leds;

	int         seed;
	int         tests_run;
	string      test_name;
	word_t      prog [IMEM_DEPTH];
	int         prog_len;
	reg_idx_t   exp_rd [$];
	word_t      exp_data [$];
	logic [3:0] exp_leds;

	riscv_core #(
		.IMEM_DEPTH (IMEM_DEPTH),
		.DMEM_DEPTH (64)
	) i_dut (
		.i_clk       (clk),
		.i_arst_n    (arst_n),
		.i_run       (run),
		.i_load_en   (load_en),
		.i_load_addr (load_addr),
		.i_load_data (load_data),
		.o_wb_en     (wb_en),
		.o_wb_rd     (wb_rd),
		.o_wb_data   (wb_data),
		.o_leds      (leds)
	);

	always #20 clk = ~clk;

	// inputs change and outputs are sampled 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic stop_on_failure();
		$display("Some tests failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_wb(input string name, input reg_idx_t rd, input word_t data);
		if (wb_rd !== rd || wb_data !== data) begin
			$display("Error: test %s write-back expected x%0d = %h, actual x%0d = %h",
				name, rd, data, wb_rd, wb_data);
			stop_on_failure();
		end
	endtask

	task automatic check_leds(input string name, input logic [3:0] expected);
		if (leds !== expected) begin
			$display("Error: test %s leds expected %h, actual %h", name, expected, leds);
			stop_on_failure();
		end
	endtask

	task automatic check_no_wb(input string name, input int cycles);
		int n;
		for (n = 0; n < cycles; n++) begin
			next_cycle();
			if (wb_en !== 1'b0) begin
				$display("test %s: unexpected write-back to x%0d", name, wb_rd);
				stop_on_failure();
			end
		end
	endtask

	task automatic add_word(input word_t w);
		if (prog_len >= IMEM_DEPTH) begin
			$display("test %s: program does not fit in instruction memory", test_name);
			stop_on_failure();
		end else begin
			prog[prog_len] = w;
			prog_len++;
		end
	endtask

	task automatic run_test();
		int idx;
		int waited;
		run = 1'b0;
		check_no_wb(test_name, DRAIN_CYCLES); // the old program only spins on its self-branch
		for (idx = 0; idx < prog_len; idx++) begin
			load_en   = 1'b1;
			load_addr = idx[ADDR_W-1:0];
			load_data = prog[idx];
			next_cycle();
		end
		load_en = 1'b0;
		run     = 1'b1;
		for (idx = 0; idx < exp_rd.size(); idx++) begin
			waited = 0;
			next_cycle();
			while (wb_en !== 1'b1 && waited < TIMEOUT_CYCLES) begin
				next_cycle();
				waited++;
			end
			if (wb_en !== 1'b1) begin
				$display("test %s: no write-back arrived within %0d cycles",
					test_name, TIMEOUT_CYCLES);
				stop_on_failure();
			end
			check_wb(test_name, exp_rd[idx], exp_data[idx]);
		end
		check_no_wb(test_name, QUIET_CYCLES); // skipped instructions must stay silent
		check_leds(test_name, exp_leds);
	endtask

	task automatic process_line(input string line);
		byte   tag;
		logic  ok;
		int    rd_val;
		int    pad;
		word_t value;
		tag = line.getc(0);
		ok  = 1'b1;
		case (tag)
			"T": begin
				ok       = ($sscanf(line, "T %s", test_name) == 1);
				prog_len = 0;
				exp_leds = '0;
				exp_rd.delete();
				exp_data.delete();
			end
			"P": begin
				ok = ($sscanf(line, "P %h", value) == 1);
				add_word(value);
			end
			"N": begin
				pad = $unsigned($random(seed)) % 4; // padding only shifts timing
				repeat (pad) add_word(NOP_INST);
			end
			"W": begin
				ok = ($sscanf(line, "W %d %h", rd_val, value) == 2);
				exp_rd.push_back(reg_idx_t'(rd_val));
				exp_data.push_back(value);
			end
			"L": begin
				ok       = ($sscanf(line, "L %h", value) == 1);
				exp_leds = value[3:0];
			end
			"E": begin
				run_test();
				tests_run++;
			end
			default: begin
				ok = 1'b1; // comment or blank line
			end
		endcase
		if (!ok) begin
			$display("malformed record in the vectors file: %s", line);
			stop_on_failure();
		end
	endtask

	initial begin
		int    fd;
		int    got;
		string line;
		seed      = 32'h228c_b3cb;
		tests_run = 0;
		prog_len  = 0;
		exp_leds  = '0;
		test_name = "reset";
		arst_n    = 1'b0;
		run       = 1'b0;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		repeat (4) @(posedge clk);
		#2;
		arst_n = 1'b1;
		check_no_wb("reset", QUIET_CYCLES);
		check_leds("reset", 4'h0);
		fd = $fopen("tests/riscv_core_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/riscv_core_vectors.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				got  = $fgets(line, fd);
				if (got > 0) begin
					process_line(line);
				end
			end
			$fclose(fd);
		end
		if (tests_run > 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("no complete test was found in the vectors file");
			stop_on_failure();
		end
	end

endmodule

// File: riscv_core.f
hw/riscv_pkg.sv
hw/pipe_reg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_controller.sv
hw/riscv_core.sv
tests/riscv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= riscv_core_tb
LOG       ?= sim.log
FILELIST  ?= riscv_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/100ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/riscv_core_vectors.txt
# records: T <name> | P <instruction hex> | N (random NOP padding) | W <rd> <data hex> | L <leds hex> | E
# every program ends in beq x0, x0, 0 with a NOP in its delay slot
T alu
P 06400093 # addi x1, x0, 100
P ffa00113 # addi x2, x0, -6
P 00000013
P 00000013
N
P 002081b3 # add  x3, x1, x2
P 40110233 # sub  x4, x2, x1
P 0020f2b3 # and  x5, x1, x2
N
P 0020e333 # or   x6, x1, x2
P 0020c3b3 # xor  x7, x1, x2
N
P 00000063
P 00000013
W 1 00000064
W 2 fffffffa
W 3 0000005e
W 4 ffffff96
W 5 00000060
W 6 fffffffe
W 7 ffffff9e
L 0
E
T lui_neg
P 12345437 # lui  x8, 0x12345
P fff00493 # addi x9, x0, -1
P fffff537 # lui  x10, 0xfffff
P 00500013 # addi x0, x0, 5
P 80000593 # addi x11, x0, -2048
P 00000013
P 00000013
N
P fff40613 # addi x12, x8, -1
P 00948033 # add  x0, x9, x9
N
P 00000063
P 00000013
W 8 12345000
W 9 ffffffff
W 10 fffff000
W 11 fffff800
W 12 12344fff
L 0
E
T mem
P 05a00693 # addi x13, x0, 0x5a
P 04000713 # addi x14, x0, 0x40
P 00000013
P 00000013
N
P 00d72023 # sw   x13, 0(x14)
P 00072783 # lw   x15, 0(x14)
P 00d02023 # sw   x13, 0(x0), drives the LEDs
P 00002803 # lw   x16, 0(x0)
N
P 00000063
P 00000013
W 13 0000005a
W 14 00000040
W 15 0000005a
W 16 0000005a
L a
E
T branch
P 00300893 # addi x17, x0, 3
P 00300913 # addi x18, x0, 3
P 00400993 # addi x19, x0, 4
P 00000013
P 00000013
N
P 01288663 # beq  x17, x18, +12 taken
P 00100a13 # addi x20, x0, 1 delay slot
P 00200a93 # addi x21, x0, 2 skipped
P 01389663 # bne  x17, x19, +12 taken
P 00300b13 # addi x22, x0, 3 delay slot
P 00400a93 # addi x21, x0, 4 skipped
P 01388663 # beq  x17, x19, +12 not taken
P 00500b93 # addi x23, x0, 5
P 01289663 # bne  x17, x18, +12 not taken
P 00600c13 # addi x24, x0, 6
P 00700c93 # addi x25, x0, 7
N
P 00000063
P 00000013
W 17 00000003
W 18 00000003
W 19 00000004
W 20 00000001
W 22 00000003
W 23 00000005
W 24 00000006
W 25 00000007
L a
E
T stale
N
P 00700d13 # addi x26, x0, 7
P 00000013
P 00000013
P 00900d13 # addi x26, x0, 9
P 000d0db3 # add  x27, x26, x0 reads the old 7
P 000d0e33 # add  x28, x26, x0 reads the old 7
P 000d0eb3 # add  x29, x26, x0 reads 9 through the write-through
N
P 00000063
P 00000013
W 26 00000007
W 26 00000009
W 27 00000007
W 28 00000007
W 29 00000009
L a
E
